//--- sc2661Uart.f
common/uartPkg.sv
registers/uartRegisterFile.sv
logic/uartReceiver.sv
logic/uartTransmitter.sv
logic/uartTop.sv
tests/uartTb.sv

//--- runSim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f sc2661Uart.f --top-module uartTb -o uartSim
./obj_dir/uartSim | tee sim.log

if grep -q "Done: errors found" sim.log; then
   echo "Simulation FAILED"
   exit 1
fi
echo "Simulation PASSED"

//--- tests/uartTb.sv
`timescale 1ns/1ps
`default_nettype none

module uartTb;

   localparam int BitPeriod     = uartPkg::DEFAULT_BIT_PERIOD;
   localparam int TimeoutCycles = 30 * 10 * BitPeriod * 2;   // 30 frames with double margin

   logic                  BRCLK = 1'b0;
   logic                  cmd_resetError;
   uartPkg::regAddr_t     ADDRESS;
   logic                  CE_n;
   logic                  READ_n;
   uartPkg::dataByte_t    D;
   uartPkg::dataByte_t    D_OUT;
   logic                  RXD;
   logic                  TXD;
   logic                  DCD_n;
   logic                  DSR_n;
   logic                  DTR_n;
   logic                  RTS_n;
   logic                  RXDRDY_n;
   logic                  TXDRDY_n;
   logic                  TXEMT_n;

   // Expected status bits held by the model
   logic                  expTxReady;
   logic                  expRxReady;
   logic                  expOverrun;
   logic                  expLineChange;
   logic [31:0]           rngState = 32'd55;
   int                    cycleCount = 0;

   uartTop u_dut (
      .BRCLK(BRCLK), .cmd_resetError(cmd_resetError),
      .ADDRESS(ADDRESS), .CE_n(CE_n), .READ_n(READ_n), .D(D), .D_OUT(D_OUT),
      .RXD(RXD), .TXD(TXD), .DCD_n(DCD_n), .DSR_n(DSR_n), .DTR_n(DTR_n), .RTS_n(RTS_n),
      .RXDRDY_n(RXDRDY_n), .TXDRDY_n(TXDRDY_n), .TXEMT_n(TXEMT_n)
   );

   always #20 BRCLK = ~BRCLK;   // 40 ns period

   always @(posedge BRCLK) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TimeoutCycles) begin
         $display("Timeout: run still busy after %0d cycles", TimeoutCycles);
         $display("Done: errors found");
         $fatal(1, "Timeout");
      end
   end

   // ------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------
   task automatic checkByte(input string name, input uartPkg::dataByte_t exp,
                            input uartPkg::dataByte_t act);
      if (exp !== act) begin
         $display("error %s: expected %h, actual %h", name, exp, act);
         $display("Done: errors found");
         $fatal(1, "Byte mismatch");
      end
   endtask

   task automatic checkStatus(input string name, input uartPkg::statusReg_t exp,
                              input uartPkg::statusReg_t act);
      if (exp !== act) begin
         $display("error %s: expected %b, actual %b", name, exp, act);
         $display("Done: errors found");
         $fatal(1, "Status mismatch");
      end
   endtask

   task automatic checkPin(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("error %s: expected %b, actual %b", name, exp, act);
         $display("Done: errors found");
         $fatal(1, "Pin mismatch");
      end
   endtask

   // ------------------------------------------------------------
   // Stimulus and model helpers start and end 2 ns after an edge
   // ------------------------------------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic randomByte(output uartPkg::dataByte_t value);
      rngState = xorshift(rngState);
      value    = rngState[7:0];
   endtask

   function automatic uartPkg::commandReg_t makeCommand(input uartPkg::opMode_e mode,
         input logic rxEn, input logic txEn, input logic clear);
      uartPkg::commandReg_t c;
      c             = '0;
      c.opMode      = mode;
      c.rxEnable    = rxEn;
      c.txEnable    = txEn;
      c.clearErrors = clear;
      return c;
   endfunction

   function automatic uartPkg::statusReg_t expectedStatus();
      uartPkg::statusReg_t s;
      s            = '0;   // Parity and frame error stay 0
      s.dsrLow     = !DSR_n;
      s.dcdLow     = !DCD_n;
      s.overrun    = expOverrun;
      s.lineChange = expLineChange;
      s.rxReady    = expRxReady;
      s.txReady    = expTxReady;
      return s;
   endfunction

   task automatic writeReg(input uartPkg::regAddr_t addr, input uartPkg::dataByte_t value);
      ADDRESS = addr;
      D       = value;
      READ_n  = 1'b1;
      CE_n    = 1'b0;   // One cycle per access
      @(posedge BRCLK);
      #2;
      CE_n    = 1'b1;
   endtask

   task automatic readReg(input uartPkg::regAddr_t addr, output uartPkg::dataByte_t value);
      ADDRESS = addr;
      READ_n  = 1'b0;
      CE_n    = 1'b0;
      @(posedge BRCLK);
      #1;
      value   = D_OUT;   // Output register loaded while strobe still low
      #1;
      CE_n    = 1'b1;
      READ_n  = 1'b1;
   endtask

   task automatic checkStatusRead(input string name);
      uartPkg::dataByte_t value;
      readReg(uartPkg::ADDR_STATUS, value);
      checkStatus(name, expectedStatus(), uartPkg::statusReg_t'(value));
      expLineChange = 1'b0;   // Cleared by the read
   endtask

   task automatic waitRxReady();
      do begin
         @(posedge BRCLK);
         #1;
      end while (RXDRDY_n);
      #1;
   endtask

   task automatic waitTxReady();
      do begin
         @(posedge BRCLK);
         #1;
      end while (TXDRDY_n);
      #1;
   endtask

   // 8N1 frame on RXD with LSB first
   task automatic driveFrame(input uartPkg::dataByte_t value);
      logic [9:0] frame;
      frame = {1'b1, value, 1'b0};   // Stop, data, start
      for (int k = 0; k < 10; k++) begin
         RXD = frame[k];
         repeat (BitPeriod) @(posedge BRCLK);
         #2;
      end
   endtask

   // Mid-bit sampling of one TXD frame
   task automatic captureFrame(output uartPkg::dataByte_t value);
      @(negedge TXD);
      repeat (BitPeriod / 2) @(posedge BRCLK);
      #1;
      checkPin("tx start bit", 1'b0, TXD);
      for (int k = 0; k < 8; k++) begin
         repeat (BitPeriod) @(posedge BRCLK);
         #1;
         value[k] = TXD;
      end
      repeat (BitPeriod) @(posedge BRCLK);
      #1;
      checkPin("tx stop bit", 1'b1, TXD);
      #1;
   endtask

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------
   initial begin
      uartPkg::dataByte_t    value;
      uartPkg::dataByte_t    sent;
      uartPkg::dataByte_t    second;
      uartPkg::dataByte_t    expMode;
      uartPkg::commandReg_t  cmd;

      cmd_resetError = 1'b1;
      ADDRESS        = uartPkg::ADDR_DATA;
      CE_n           = 1'b1;
      READ_n         = 1'b1;
      D              = '0;
      RXD            = 1'b1;   // Line idle
      DCD_n          = 1'b0;   // Carrier present
      DSR_n          = 1'b1;
      expTxReady     = 1'b1;
      expRxReady     = 1'b0;
      expOverrun     = 1'b0;
      expLineChange  = 1'b0;
      repeat (5) @(posedge BRCLK);
      #2;
      cmd_resetError = 1'b0;

      // Reset state
      checkPin("reset TXD", 1'b1, TXD);
      checkPin("reset RXDRDY_n", 1'b1, RXDRDY_n);
      checkPin("reset TXDRDY_n", 1'b1, TXDRDY_n);
      checkPin("reset DTR_n", 1'b1, DTR_n);
      checkPin("reset RTS_n", 1'b1, RTS_n);
      checkPin("reset TXEMT_n", 1'b1, TXEMT_n);
      readReg(uartPkg::ADDR_COMMAND, value);
      checkByte("reset command", 8'h00, value);
      readReg(uartPkg::ADDR_MODE, value);
      checkByte("reset mode", 8'h00, value);
      checkByte("bus idle", 8'h00, D_OUT);   // Bus reads zero once the strobe is gone
      checkStatusRead("reset status");

      // Register access with random command and mode
      for (int n = 0; n < 4; n++) begin
         randomByte(value);
         cmd        = uartPkg::commandReg_t'(value);
         cmd.opMode = uartPkg::NORMAL;
         randomByte(expMode);
         writeReg(uartPkg::ADDR_COMMAND, cmd);
         writeReg(uartPkg::ADDR_MODE, expMode);
         readReg(uartPkg::ADDR_COMMAND, value);
         checkByte("command readback", cmd, value);
         readReg(uartPkg::ADDR_MODE, value);
         checkByte("mode readback", expMode, value);
         checkPin("DTR_n from dtrLow", !cmd.dtrLow, DTR_n);
         checkPin("RTS_n from rtsLow", !cmd.rtsLow, RTS_n);
      end

      // Modem line change while the receiver runs
      writeReg(uartPkg::ADDR_COMMAND, makeCommand(uartPkg::NORMAL, 1'b1, 1'b0, 1'b0));
      DCD_n = !DCD_n;
      repeat (2) @(posedge BRCLK);
      #2;
      expLineChange = 1'b1;
      checkPin("TXEMT_n on line change", 1'b0, TXEMT_n);
      checkStatusRead("status after DCD change");
      checkStatusRead("status after clear");
      checkPin("TXEMT_n after status read", 1'b1, TXEMT_n);

      // Transmit
      writeReg(uartPkg::ADDR_COMMAND, makeCommand(uartPkg::NORMAL, 1'b0, 1'b1, 1'b0));
      for (int n = 0; n < 5; n++) begin
         randomByte(sent);
         writeReg(uartPkg::ADDR_DATA, sent);
         captureFrame(value);
         checkByte("tx frame", sent, value);
         checkPin("TXDRDY_n during frame", 1'b1, TXDRDY_n);
         expTxReady = 1'b0;   // Stop bit still on the line
         checkStatusRead("status during tx frame");
         expTxReady = 1'b1;
         waitTxReady();
         expLineChange = 1'b1;   // Frame sent
         checkStatusRead("status after tx frame");
      end

      // Receive
      writeReg(uartPkg::ADDR_COMMAND, makeCommand(uartPkg::NORMAL, 1'b1, 1'b0, 1'b0));
      for (int n = 0; n < 5; n++) begin
         randomByte(sent);
         driveFrame(sent);
         waitRxReady();
         readReg(uartPkg::ADDR_DATA, value);
         checkByte("rx byte", sent, value);
         checkPin("RXDRDY_n after read", 1'b1, RXDRDY_n);
      end

      // Overrun from two frames with no read between
      randomByte(sent);
      randomByte(second);
      driveFrame(sent);
      driveFrame(second);
      waitRxReady();
      expOverrun = 1'b1;
      expRxReady = 1'b1;
      checkStatusRead("status with overrun");
      writeReg(uartPkg::ADDR_COMMAND, makeCommand(uartPkg::NORMAL, 1'b1, 1'b0, 1'b1));
      expOverrun = 1'b0;
      checkStatusRead("status after clearErrors");
      readReg(uartPkg::ADDR_DATA, value);
      checkByte("rx byte after overrun", second, value);
      expRxReady = 1'b0;

      // Local loopback
      writeReg(uartPkg::ADDR_COMMAND,
               makeCommand(uartPkg::LOCAL_LOOPBACK, 1'b1, 1'b1, 1'b0));
      for (int n = 0; n < 3; n++) begin
         randomByte(sent);
         writeReg(uartPkg::ADDR_DATA, sent);
         waitRxReady();
         readReg(uartPkg::ADDR_DATA, value);
         checkByte("local loopback byte", sent, value);
         waitTxReady();
         expLineChange = 1'b1;
      end
      checkStatusRead("status after local loopback");

      // Remote loopback sends the RXD frame back on TXD
      writeReg(uartPkg::ADDR_COMMAND,
               makeCommand(uartPkg::REMOTE_LOOPBACK, 1'b1, 1'b1, 1'b0));
      for (int n = 0; n < 3; n++) begin
         randomByte(sent);
         fork
            driveFrame(sent);
            captureFrame(value);
         join
         checkByte("remote loopback echo", sent, value);
         waitTxReady();
         readReg(uartPkg::ADDR_DATA, value);
         checkByte("remote loopback rhr", sent, value);
         expLineChange = 1'b1;
      end
      checkStatusRead("status after remote loopback");

      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/uartTop.sv
`timescale 1ns/1ps
`default_nettype none

module uartTop #(
   parameter int BitPeriod = uartPkg::DEFAULT_BIT_PERIOD   // BRCLK cycles per bit
) (
   input  wire                      BRCLK,
   input  wire                      cmd_resetError,
   // CPU port
   input  wire uartPkg::regAddr_t   ADDRESS,
   input  wire                      CE_n,
   input  wire                      READ_n,
   input  wire uartPkg::dataByte_t  D,
   output wire uartPkg::dataByte_t  D_OUT,
   // Serial and modem lines
   input  wire                      RXD,
   output wire                      TXD,
   input  wire                      DCD_n,
   input  wire                      DSR_n,
   output wire                      DTR_n,
   output wire                      RTS_n,
   // Interrupt flags
   output wire                      RXDRDY_n,
   output wire                      TXDRDY_n,
   output wire                      TXEMT_n
);

   uartPkg::commandReg_t   command;
   uartPkg::dataByte_t     thrData;
   uartPkg::dataByte_t     rxData;
   logic                   thrLoad;
   logic                   txStart;
   logic                   txDone;
   logic                   frameStart;
   logic                   byteDone;
   logic                   rxSerialIn;

   // Local loopback, receiver listens to own TXD
   assign rxSerialIn = (command.opMode == uartPkg::LOCAL_LOOPBACK) ? TXD : RXD;

   // ------------------------------------------------------------
   // Blocks
   // ------------------------------------------------------------
   uartRegisterFile uRegisterFile (
      .BRCLK(BRCLK), .cmd_resetError(cmd_resetError),
      .ADDRESS(ADDRESS), .CE_n(CE_n), .READ_n(READ_n), .D(D),
      .DCD_n(DCD_n), .DSR_n(DSR_n),
      .frameStart(frameStart), .byteDone(byteDone), .rxData(rxData),
      .txStart(txStart), .txDone(txDone),
      .D_OUT(D_OUT), .command(command), .thrLoad(thrLoad), .thrData(thrData),
      .DTR_n(DTR_n), .RTS_n(RTS_n),
      .RXDRDY_n(RXDRDY_n), .TXDRDY_n(TXDRDY_n), .TXEMT_n(TXEMT_n)
   );

   uartReceiver #(.BitPeriod(BitPeriod)) uReceiver (
      .BRCLK(BRCLK), .cmd_resetError(cmd_resetError),
      .rxEnable(command.rxEnable), .serialIn(rxSerialIn),
      .frameStart(frameStart), .byteDone(byteDone), .rxData(rxData)
   );

   uartTransmitter #(.BitPeriod(BitPeriod)) uTransmitter (
      .BRCLK(BRCLK), .cmd_resetError(cmd_resetError),
      .txEnable(command.txEnable), .thrLoad(thrLoad), .thrData(thrData),
      .TXD(TXD), .txStart(txStart), .txDone(txDone)
   );

endmodule

`default_nettype wire

//--- logic/uartTransmitter.sv
`timescale 1ns/1ps
`default_nettype none

module uartTransmitter #(
   parameter int BitPeriod = uartPkg::DEFAULT_BIT_PERIOD
) (
   input  wire                      BRCLK,
   input  wire                      cmd_resetError,
   input  wire                      txEnable,
   input  wire                      thrLoad,
   input  wire uartPkg::dataByte_t  thrData,
   output logic                     TXD,
   output logic                     txStart,
   output logic                     txDone
);

   localparam int CntWidth = $clog2(BitPeriod + 1);

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP,
      TX_DONE    // One cycle to report the frame
   } txState_e;

   txState_e               state;
   logic [CntWidth-1:0]    bitCnt;
   uartPkg::bitIndex_t     bitIdx;
   uartPkg::dataByte_t     holdReg;   // THR
   logic                   pending;   // Byte waiting to go out
   logic                   lastTick;

   assign lastTick = (bitCnt == CntWidth'(BitPeriod - 1));
   assign txStart  = txEnable && (state == TX_IDLE) && pending;
   assign txDone   = txEnable && (state == TX_DONE);

   // Late load overwrites THR but adds no frame
   always_ff @(posedge BRCLK) begin
      if (thrLoad) holdReg <= thrData;
   end

   always_ff @(posedge BRCLK) begin
      if (cmd_resetError) pending <= 1'b0;
      else if (thrLoad) pending <= 1'b1;
      else if (txDone) pending <= 1'b0;
   end

   // ------------------------------------------------------------
   // Serialiser, 8N1 LSB first
   // ------------------------------------------------------------
   always_ff @(posedge BRCLK) begin
      if (cmd_resetError || !txEnable) begin
         state  <= TX_IDLE;
         TXD    <= 1'b1;   // Line idles high
         bitCnt <= '0;
         bitIdx <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               if (pending) begin
                  state  <= TX_START;
                  TXD    <= 1'b0;   // Start bit
                  bitCnt <= '0;
               end
            end
            TX_START: begin
               if (lastTick) begin
                  state  <= TX_DATA;
                  TXD    <= holdReg[0];
                  bitIdx <= '0;
                  bitCnt <= '0;
               end else bitCnt <= bitCnt + 1'b1;
            end
            TX_DATA: begin
               if (lastTick) begin
                  bitCnt <= '0;
                  if (bitIdx == 3'd7) begin
                     state <= TX_STOP;
                     TXD   <= 1'b1;   // Stop bit
                  end else begin
                     bitIdx <= bitIdx + 1'b1;
                     TXD    <= holdReg[bitIdx + 3'd1];
                  end
               end else bitCnt <= bitCnt + 1'b1;
            end
            TX_STOP: begin
               if (lastTick) begin
                  state  <= TX_DONE;
                  bitCnt <= '0;
               end else bitCnt <= bitCnt + 1'b1;
            end
            TX_DONE: state <= TX_IDLE;
            default: state <= TX_IDLE;
         endcase
      end
   end

   // Every path into idle leaves the line high
   a_idleHigh: assert property (@(posedge BRCLK) disable iff (cmd_resetError)
      (state == TX_IDLE) |-> TXD);

endmodule

`default_nettype wire

//--- logic/uartReceiver.sv
`timescale 1ns/1ps
`default_nettype none

module uartReceiver #(
   parameter int BitPeriod = uartPkg::DEFAULT_BIT_PERIOD
) (
   input  wire                  BRCLK,
   input  wire                  cmd_resetError,
   input  wire                  rxEnable,
   input  wire                  serialIn,
   output logic                 frameStart,
   output logic                 byteDone,
   output uartPkg::dataByte_t   rxData
);

   localparam int CntWidth   = $clog2(BitPeriod + 1);
   localparam int HalfPeriod = BitPeriod / 2;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_START,    // Half bit to start-bit middle
      RX_WAIT,     // Full bit to next data middle
      RX_SAMPLE,
      RX_STOP
   } rxState_e;

   rxState_e               state;
   logic [CntWidth-1:0]    bitCnt;
   uartPkg::bitIndex_t     bitIdx;
   uartPkg::dataByte_t     shiftReg;

   // ------------------------------------------------------------
   // Frame FSM
   // ------------------------------------------------------------
   always_ff @(posedge BRCLK) begin
      if (cmd_resetError || !rxEnable) begin
         state  <= RX_IDLE;   // Disable drops any frame in progress
         bitCnt <= '0;
         bitIdx <= '0;
      end else begin
         case (state)
            RX_IDLE: begin
               if (!serialIn) begin   // Falling edge of start bit
                  state  <= RX_START;
                  bitCnt <= CntWidth'(1);
                  bitIdx <= '0;
               end
            end
            RX_START: begin
               if (bitCnt == CntWidth'(HalfPeriod)) begin
                  state  <= RX_WAIT;
                  bitCnt <= CntWidth'(1);
               end else bitCnt <= bitCnt + 1'b1;
            end
            RX_WAIT: begin
               if (bitCnt == CntWidth'(BitPeriod - 1)) state <= RX_SAMPLE;
               else bitCnt <= bitCnt + 1'b1;
            end
            RX_SAMPLE: begin
               bitCnt <= CntWidth'(1);
               bitIdx <= bitIdx + 1'b1;
               state  <= (bitIdx == 3'd7) ? RX_STOP : RX_WAIT;
            end
            RX_STOP: begin
               // Stop level not checked
               if (bitCnt == CntWidth'(BitPeriod)) state <= RX_IDLE;
               else bitCnt <= bitCnt + 1'b1;
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // LSB arrives first, shift in from the top
   always_ff @(posedge BRCLK) begin
      if (rxEnable && state == RX_SAMPLE) shiftReg <= {serialIn, shiftReg[7:1]};
   end

   assign rxData     = shiftReg;
   assign frameStart = rxEnable && (state == RX_IDLE) && !serialIn;
   assign byteDone   = rxEnable && (state == RX_STOP) && (bitCnt == CntWidth'(BitPeriod));

   // Start detect and byte completion are separate events
   a_startNotDone: assert property (@(posedge BRCLK) disable iff (cmd_resetError)
      !(frameStart && byteDone));

endmodule

`default_nettype wire

//--- registers/uartRegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

module uartRegisterFile (
   input  wire                        BRCLK,
   input  wire                        cmd_resetError,
   input  wire uartPkg::regAddr_t     ADDRESS,
   input  wire                        CE_n,
   input  wire                        READ_n,
   input  wire uartPkg::dataByte_t    D,
   input  wire                        DCD_n,
   input  wire                        DSR_n,
   input  wire                        frameStart,   // Receiver found a start bit
   input  wire                        byteDone,     // Receiver byte complete
   input  wire uartPkg::dataByte_t    rxData,
   input  wire                        txStart,      // Transmitter left idle
   input  wire                        txDone,       // Stop bit finished
   output uartPkg::dataByte_t         D_OUT,
   output uartPkg::commandReg_t       command,
   output logic                       thrLoad,
   output uartPkg::dataByte_t         thrData,
   output logic                       DTR_n,
   output logic                       RTS_n,
   output logic                       RXDRDY_n,
   output logic                       TXDRDY_n,
   output logic                       TXEMT_n
);

   uartPkg::dataByte_t    modeReg;
   uartPkg::dataByte_t    rhr;          // Receive holding register
   uartPkg::dataByte_t    dataOut;      // Read data, shown one cycle later
   uartPkg::commandReg_t  cmdIn;        // Bus data seen as a command
   uartPkg::statusReg_t   statusNow;
   logic                  txReady;
   logic                  rxReady;
   logic                  overrun;
   logic                  lineChange;
   logic                  dcdLow;
   logic                  dsrLow;
   logic                  cpuWrite;
   logic                  cpuRead;
   logic                  modemChange;
   logic                  remoteEcho;

   assign cpuWrite = !CE_n && READ_n;   // One access per enabled cycle
   assign cpuRead  = !CE_n && !READ_n;
   assign cmdIn    = uartPkg::commandReg_t'(D);

   // Last sample differs from the pin, only watched while an engine runs
   assign modemChange = (command.rxEnable || command.txEnable) &&
                        ((dcdLow != !DCD_n) || (dsrLow != !DSR_n));
   assign remoteEcho  = byteDone && (command.opMode == uartPkg::REMOTE_LOOPBACK);

   assign statusNow = '{dsrLow: dsrLow, dcdLow: dcdLow, frameError: 1'b0,
                        overrun: overrun, parityError: 1'b0, lineChange: lineChange,
                        rxReady: rxReady, txReady: txReady};

   // ------------------------------------------------------------
   // Bus decode and status update
   // ------------------------------------------------------------
   always_ff @(posedge BRCLK) begin
      if (cmd_resetError) begin
         command    <= '0;
         modeReg    <= '0;
         rhr        <= '0;
         dataOut    <= '0;
         thrLoad    <= 1'b0;
         thrData    <= '0;
         txReady    <= 1'b1;   // THR empty
         rxReady    <= 1'b0;
         overrun    <= 1'b0;
         lineChange <= 1'b0;
         dcdLow     <= 1'b0;
         dsrLow     <= 1'b0;
      end else begin
         thrLoad <= 1'b0;
         dcdLow  <= !DCD_n;   // Modem lines sampled every cycle
         dsrLow  <= !DSR_n;

         if (cpuWrite) begin
            case (ADDRESS)
               uartPkg::ADDR_DATA: begin
                  thrLoad <= 1'b1;
                  thrData <= D;
               end
               uartPkg::ADDR_MODE: modeReg <= D;
               uartPkg::ADDR_COMMAND: begin
                  command <= cmdIn;
                  if (cmdIn.clearErrors) overrun <= 1'b0;
                  if (!cmdIn.rxEnable) rxReady <= 1'b0;   // RHR empty when receiver off
               end
               default: ;   // Status is read only
            endcase
         end else if (cpuRead) begin
            case (ADDRESS)
               uartPkg::ADDR_DATA: begin
                  dataOut <= rhr;
                  rxReady <= 1'b0;
               end
               uartPkg::ADDR_STATUS: begin
                  dataOut    <= statusNow;
                  lineChange <= 1'b0;
               end
               uartPkg::ADDR_MODE:    dataOut <= modeReg;
               default:               dataOut <= command;
            endcase
         end

         // Remote loopback feeds the transmitter, CPU write has priority
         if (remoteEcho && !(cpuWrite && ADDRESS == uartPkg::ADDR_DATA)) begin
            thrLoad <= 1'b1;
            thrData <= rxData;
         end

         // Engine events come last so they win over CPU clears
         if (txStart) txReady <= 1'b0;
         if (txDone) begin
            txReady    <= 1'b1;
            lineChange <= 1'b1;   // Shift register empty
         end
         if (frameStart) begin
            rxReady <= 1'b0;
            if (rxReady) overrun <= 1'b1;   // Previous byte never read
         end
         if (byteDone) begin
            rxReady <= 1'b1;
            rhr     <= rxData;
         end
         if (modemChange) lineChange <= 1'b1;
      end
   end

   // ------------------------------------------------------------
   // Pins
   // ------------------------------------------------------------
   assign D_OUT    = cpuRead ? dataOut : '0;
   assign DTR_n    = !command.dtrLow;
   assign RTS_n    = !command.rtsLow;
   assign RXDRDY_n = command.rxEnable ? !rxReady : 1'b1;   // Valid only when enabled
   assign TXDRDY_n = command.txEnable ? !txReady : 1'b1;
   assign TXEMT_n  = !lineChange;

   // No transmit request leaves the block right after a reset cycle
   a_noLoadAfterReset: assert property (@(posedge BRCLK) cmd_resetError |=> !thrLoad);

   // A start bit empties RHR and the receiver is busy next cycle
   a_frameStartClears: assert property (@(posedge BRCLK) disable iff (cmd_resetError)
      frameStart |=> !(rxReady || frameStart));

endmodule

`default_nettype wire

//--- common/uartPkg.sv
`default_nettype none

package uartPkg;

   // ------------------------------------------------------------
   // Widths with a meaning
   // ------------------------------------------------------------
   typedef logic [7:0] dataByte_t;   // One character or register value
   typedef logic [1:0] regAddr_t;    // CPU register select
   typedef logic [2:0] bitIndex_t;   // Bit position inside a character

   // BRCLK cycles per serial bit
   localparam int DEFAULT_BIT_PERIOD = 16;

   // CPU register map
   localparam regAddr_t ADDR_DATA    = 2'd0;   // THR on write, RHR on read
   localparam regAddr_t ADDR_STATUS  = 2'd1;   // Read only
   localparam regAddr_t ADDR_MODE    = 2'd2;
   localparam regAddr_t ADDR_COMMAND = 2'd3;

   // Command bits 7:6, ECHO acts as NORMAL here
   typedef enum logic [1:0] {
      NORMAL          = 2'b00,
      ECHO            = 2'b01,
      LOCAL_LOOPBACK  = 2'b10,   // TXD looped into receiver
      REMOTE_LOOPBACK = 2'b11    // Received bytes sent back out
   } opMode_e;

   // ------------------------------------------------------------
   // Register layouts, top bit first
   // ------------------------------------------------------------
   typedef struct packed {
      opMode_e opMode;        // Bits 7:6
      logic    rtsLow;        // Force RTS_n low
      logic    clearErrors;   // Clears overrun on write
      logic    cr3;           // Stored only
      logic    rxEnable;
      logic    dtrLow;        // Force DTR_n low
      logic    txEnable;
   } commandReg_t;

   typedef struct packed {
      logic dsrLow;        // Inverted DSR_n
      logic dcdLow;        // Inverted DCD_n
      logic frameError;    // Reads 0
      logic overrun;
      logic parityError;   // Reads 0
      logic lineChange;    // Modem line change or frame sent
      logic rxReady;
      logic txReady;
   } statusReg_t;

endpackage

`default_nettype wire
